// ==== fetch_pkg.sv ====
package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////////////////////

	// one machine word, also the pc width
	localparam int data_width = 32;

	// instruction memory word index
	localparam int imem_addr_width = 7;
	localparam int imem_depth = 128;

	// apb byte address bus
	localparam int apb_addr_width = 12;

	////////////////////////////////////////////////////////////////////////////
	// apb address map
	////////////////////////////////////////////////////////////////////////////

	// memory words sit at 0x000 up to 0x1fc
	// run control register right above them
	localparam logic [apb_addr_width-1:0] ctrl_addr = 12'h200;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	// where the next pc comes from, driven by the control unit
	typedef enum logic [1:0] {
		src_next     = 2'b00,
		src_branch   = 2'b01,
		src_jump     = 2'b10,
		src_register = 2'b11
	} pc_src_t;

	// primary opcode field, instruction bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,
		op_j     = 6'b000010,
		op_jal   = 6'b000011,
		op_beq   = 6'b000100,
		op_bne   = 6'b000101,
		op_addi  = 6'b001000,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011,
		op_halt  = 6'b111111
	} opcode_t;

	// all zero word decodes as sll r0,r0,0 so it is a safe bubble
	localparam logic [data_width-1:0] nop_word = '0;

endpackage

// ==== pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             run,
	input  logic                             stall,
	input  logic                             halt,
	input  fetch_pkg::pc_src_t               pc_src,
	input  logic [fetch_pkg::data_width-1:0] branch_address,
	input  logic [fetch_pkg::data_width-1:0] jump_address,
	input  logic [fetch_pkg::data_width-1:0] register_address,
	output logic [fetch_pkg::data_width-1:0] pc,
	output logic [fetch_pkg::data_width-1:0] pc_plus_one
);
	import fetch_pkg::*;

	// selected target for the next edge
	logic [data_width-1:0] pc_target;
	// pc is allowed to move this cycle
	logic                  pc_advance;

	////////////////////////////////////////////////////////////////////////////
	// incrementer and next pc mux
	////////////////////////////////////////////////////////////////////////////

	// word addressed, so sequential fetch steps by one
	assign pc_plus_one = pc + 1'b1;

	always_comb begin
		unique case (pc_src)
			src_next:     pc_target = pc_plus_one;
			src_branch:   pc_target = branch_address;
			src_jump:     pc_target = jump_address;
			src_register: pc_target = register_address;
			// unknown select keeps the current pc
			default:      pc_target = pc;
		endcase
	end

	// frozen by hazard stall or once the halt word is addressed
	assign pc_advance = run && !stall && !halt;

	////////////////////////////////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!run) begin
			// parked at 0 while stopped
			// so every start of run begins at address 0
			pc <= '0;
		end else if (pc_advance) begin
			pc <= pc_target;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// control unit must drive a clean source select while fetching
	pc_src_known: assert property (
		@(posedge clk) disable iff (reset)
		run |-> !$isunknown(pc_src)
	) else $error("pc_src has unknown bits while running");

endmodule

// ==== imem_apb.sv ====
`timescale 1ns/1ps

module imem_apb (
	input  logic                                  clk,
	input  logic                                  reset,
	// apb slave side
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [fetch_pkg::apb_addr_width-1:0]  paddr,
	input  logic [fetch_pkg::data_width-1:0]      pwdata,
	output logic [fetch_pkg::data_width-1:0]      prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	// fetch side
	input  logic [fetch_pkg::imem_addr_width-1:0] pc,
	output logic [fetch_pkg::data_width-1:0]      instruction,
	output logic                                  halt,
	output logic                                  run
);
	import fetch_pkg::*;

	// instruction store
	logic [data_width-1:0] mem [imem_depth];

	// apb decode
	logic                       apb_access;
	logic                       mem_sel;
	logic                       ctrl_sel;
	logic [imem_addr_width-1:0] apb_index;
	logic                       mem_write_ok;
	logic                       mem_write_err;

	// shared read port
	logic [imem_addr_width-1:0] rd_index;
	logic [data_width-1:0]      rd_word;
	opcode_t                    fetched_op;

	////////////////////////////////////////////////////////////////////////////
	// apb address decode
	////////////////////////////////////////////////////////////////////////////

	// access phase, completes this cycle since there are no wait states
	assign apb_access = psel && penable;

	// memory window is everything below the control register
	assign mem_sel  = (paddr[apb_addr_width-1:imem_addr_width+2] == '0);
	assign ctrl_sel = (paddr == ctrl_addr);

	// word index from byte address bits 8:2
	assign apb_index = paddr[imem_addr_width+1:2];

	// host may only load the program while stopped
	assign mem_write_ok  = apb_access && pwrite && mem_sel && !run;
	assign mem_write_err = apb_access && pwrite && mem_sel && run;

	assign pready  = 1'b1;
	assign pslverr = mem_write_err;

	////////////////////////////////////////////////////////////////////////////
	// run control register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			run <= 1'b0;
		end else if (apb_access && pwrite && ctrl_sel) begin
			// bit 0 only, upper bits ignored
			run <= pwdata[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// memory array
	////////////////////////////////////////////////////////////////////////////

	// write lands on the access phase edge
	always_ff @(posedge clk) begin
		if (mem_write_ok) begin
			mem[apb_index] <= pwdata;
		end
	end

	// one read port, owned by fetch while running and by apb while stopped
	assign rd_index = run ? pc : apb_index;
	assign rd_word  = mem[rd_index];

	////////////////////////////////////////////////////////////////////////////
	// fetch outputs and halt detect
	////////////////////////////////////////////////////////////////////////////

	// combinational read, zero cycles from pc
	assign instruction = rd_word;

	assign fetched_op = opcode_t'(rd_word[data_width-1:data_width-6]);

	// halt only counts while the port is on the fetch side
	assign halt = run && (fetched_op == op_halt);

	////////////////////////////////////////////////////////////////////////////
	// apb read data
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		prdata = '0;
		if (ctrl_sel) begin
			prdata[0] = run;
		end else if (mem_sel && !run) begin
			// port belongs to fetch while running, so reads return 0 then
			prdata = rd_word;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// error only on an access phase, and only for a blocked write
	apb_err_in_access: assert property (
		@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable && run
	) else $error("pslverr outside a blocked access phase");

	// access phase must follow a setup phase of the same transfer
	apb_enable_needs_sel: assert property (
		@(posedge clk) disable iff (reset)
		$rose(penable) |-> psel && $past(psel)
	) else $error("penable rose without a setup phase");

endmodule

// ==== if_id_latch.sv ====
`timescale 1ns/1ps

module if_id_latch (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             run,
	input  logic                             stall,
	input  fetch_pkg::pc_src_t               pc_src,
	input  logic [fetch_pkg::data_width-1:0] instruction,
	input  logic [fetch_pkg::data_width-1:0] pc,
	input  logic [fetch_pkg::data_width-1:0] pc_plus_one,
	input  logic                             halt,
	output logic [fetch_pkg::data_width-1:0] instruction_id,
	output logic [fetch_pkg::data_width-1:0] pc_id,
	output logic [fetch_pkg::data_width-1:0] pc_next_id,
	output logic                             halt_id
);
	import fetch_pkg::*;

	// any redirect kills the word fetched this cycle
	logic flush;

	assign flush = (pc_src != src_next);

	////////////////////////////////////////////////////////////////////////////
	// fetch/decode boundary register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			instruction_id <= nop_word;
			pc_id          <= '0;
			pc_next_id     <= '0;
			halt_id        <= 1'b0;
		end else if (!run) begin
			// idle, decode sees bubbles and halt clears
			instruction_id <= nop_word;
			pc_id          <= '0;
			pc_next_id     <= '0;
			halt_id        <= 1'b0;
		end else if (stall) begin
			// hold everything for the hazard
			instruction_id <= instruction_id;
			pc_id          <= pc_id;
			pc_next_id     <= pc_next_id;
			halt_id        <= halt_id;
		end else if (flush) begin
			// wrong path word replaced by a bubble
			// pc and successor cleared with it
			instruction_id <= nop_word;
			pc_id          <= '0;
			pc_next_id     <= '0;
			// a halt already passed down is not undone
			halt_id        <= halt_id;
		end else begin
			instruction_id <= instruction;
			pc_id          <= pc;
			pc_next_id     <= pc_plus_one;
			// pc sits on the halt word so this stays set until run drops
			halt_id        <= halt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// redirect without stall always yields a bubble one edge later
	flush_gives_bubble: assert property (
		@(posedge clk) disable iff (reset)
		run && !stall && flush |=> instruction_id == nop_word && pc_next_id == '0
	) else $error("flush did not insert a bubble");

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
	input  logic                                 clk,
	input  logic                                 reset,
	// pipeline control, plain levels
	input  fetch_pkg::pc_src_t                   pc_src,
	input  logic [fetch_pkg::data_width-1:0]     branch_address,
	input  logic [fetch_pkg::data_width-1:0]     jump_address,
	input  logic [fetch_pkg::data_width-1:0]     register_address,
	input  logic                                 stall,
	// apb host port for program load and run control
	input  logic                                 psel,
	input  logic                                 penable,
	input  logic                                 pwrite,
	input  logic [fetch_pkg::apb_addr_width-1:0] paddr,
	input  logic [fetch_pkg::data_width-1:0]     pwdata,
	output logic [fetch_pkg::data_width-1:0]     prdata,
	output logic                                 pready,
	output logic                                 pslverr,
	// towards decode
	output logic [fetch_pkg::data_width-1:0]     instruction_id,
	output logic [fetch_pkg::data_width-1:0]     pc_id,
	output logic [fetch_pkg::data_width-1:0]     pc_next_id,
	output logic                                 halt_id
);
	import fetch_pkg::*;

	// run control from the apb register
	logic                  run;
	// halt word seen at the current pc
	logic                  halt;
	logic [data_width-1:0] pc;
	logic [data_width-1:0] pc_plus_one;
	logic [data_width-1:0] instruction;

	////////////////////////////////////////////////////////////////////////////
	// program counter
	////////////////////////////////////////////////////////////////////////////

	pc_unit u_pc_unit (
		.clk              (clk),
		.reset            (reset),
		.run              (run),
		.stall            (stall),
		.halt             (halt),
		.pc_src           (pc_src),
		.branch_address   (branch_address),
		.jump_address     (jump_address),
		.register_address (register_address),
		.pc               (pc),
		.pc_plus_one      (pc_plus_one)
	);

	// instruction memory, indexed by the low pc bits only
	imem_apb u_imem_apb (
		.clk         (clk),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.pc          (pc[imem_addr_width-1:0]),
		.instruction (instruction),
		.halt        (halt),
		.run         (run)
	);

	////////////////////////////////////////////////////////////////////////////
	// if/id boundary
	////////////////////////////////////////////////////////////////////////////

	if_id_latch u_if_id_latch (
		.clk            (clk),
		.reset          (reset),
		.run            (run),
		.stall          (stall),
		.pc_src         (pc_src),
		.instruction    (instruction),
		.pc             (pc),
		.pc_plus_one    (pc_plus_one),
		.halt           (halt),
		.instruction_id (instruction_id),
		.pc_id          (pc_id),
		.pc_next_id     (pc_next_id),
		.halt_id        (halt_id)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	// 8 ns period
	localparam int half_period_ns = 4;
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #half_period_ns clk = ~clk;
	end

	// release on a falling edge, away from the dut sampling edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	// preload 384, load test 96, the rest well under 100, plus reset
	localparam int test_cycles = 560;
	localparam int clock_period_ns = 8;

	logic clk;
	logic reset;

	// dut inputs
	pc_src_t               pc_src;
	logic [data_width-1:0] branch_address;
	logic [data_width-1:0] jump_address;
	logic [data_width-1:0] register_address;
	logic                  stall;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [apb_addr_width-1:0] paddr;
	logic [data_width-1:0] pwdata;

	// dut outputs
	logic [data_width-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic [data_width-1:0] instruction_id;
	logic [data_width-1:0] pc_id;
	logic [data_width-1:0] pc_next_id;
	logic                  halt_id;

	// mirror of the instruction memory
	logic [data_width-1:0] ref_mem [imem_depth];
	logic [31:0]           seed = 32'hf9a3c82a;

	int    checks;
	int    errors;
	int    tests_run;
	int    test_errors_start;
	string current_test;

	tb_clock_gen clock0 (
		.clk   (clk),
		.reset (reset)
	);

	fetch_stage dut0 (
		.clk              (clk),
		.reset            (reset),
		.pc_src           (pc_src),
		.branch_address   (branch_address),
		.jump_address     (jump_address),
		.register_address (register_address),
		.stall            (stall),
		.psel             (psel),
		.penable          (penable),
		.pwrite           (pwrite),
		.paddr            (paddr),
		.pwdata           (pwdata),
		.prdata           (prdata),
		.pready           (pready),
		.pslverr          (pslverr),
		.instruction_id   (instruction_id),
		.pc_id            (pc_id),
		.pc_next_id       (pc_next_id),
		.halt_id          (halt_id)
	);

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// numerical recipes lcg
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// random word that can never stop the fetch
	function automatic logic [31:0] random_instruction();
		logic [31:0] word;
		word = next_random();
		if (word[31:26] == op_halt) begin
			word[31:26] = op_addi;
		end
		return word;
	endfunction

	// background pattern, all seven address bits show up in the word
	function automatic logic [31:0] fill_word(input int index);
		logic [6:0] a;
		a = index[6:0];
		return {op_addi, a[6:2], a[4:0], a, 2'b01, a};
	endfunction

	task automatic compare_word(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Mismatch in %s (%s): expected %h, actual %h",
				current_test, field, expected, actual);
		end
	endtask

	// setup, access, then sample at the falling edge after completion
	task automatic apb_transfer(input logic write, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		while (!pready && waits < 16) begin
			@(negedge clk);
			waits++;
		end
		assert (pready) else begin
			errors++;
			$display("%s: apb transfer never completed, pready stayed low", current_test);
		end
		rdata = prdata;
		err = pslverr;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
			output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
			output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic set_run(input logic value);
		logic err;
		apb_write(ctrl_addr, {31'b0, value}, err);
		compare_word("ctrl pslverr", 32'b0, {31'b0, err});
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_errors_start) begin
			$display("%s: ok", current_test);
		end else begin
			$display("%s: %0d errors", current_test, errors - test_errors_start);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	// whole array defined so a wandering pc never reads x
	task automatic preload_memory();
		logic err;
		current_test = "preload";
		for (int i = 0; i < imem_depth; i++) begin
			ref_mem[i] = fill_word(i);
			apb_write(12'(i * 4), ref_mem[i], err);
			compare_word("pslverr", 32'b0, {31'b0, err});
		end
	endtask

	task automatic load_readback();
		logic [31:0] data;
		logic        err;
		start_test("load_readback");
		for (int i = 0; i < 16; i++) begin
			ref_mem[i] = random_instruction();
			apb_write(12'(i * 4), ref_mem[i], err);
			compare_word("write pslverr", 32'b0, {31'b0, err});
		end
		for (int i = 0; i < 16; i++) begin
			apb_read(12'(i * 4), data, err);
			compare_word("prdata", ref_mem[i], data);
			compare_word("read pslverr", 32'b0, {31'b0, err});
		end
		end_test();
	endtask

	task automatic sequential_fetch();
		start_test("sequential_fetch");
		set_run(1'b1);
		// first word shows up one edge after run rises
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			compare_word("pc_id", 32'(i), pc_id);
			compare_word("instruction_id", ref_mem[i], instruction_id);
			compare_word("pc_next_id", 32'(i + 1), pc_next_id);
		end
		end_test();
	endtask

	// one cycle redirect, then bubble, then the target word
	task automatic redirect(input pc_src_t src, input logic [31:0] target);
		@(negedge clk);
		pc_src = src;
		case (src)
			src_branch:   branch_address = target;
			src_jump:     jump_address = target;
			default:      register_address = target;
		endcase
		@(negedge clk);
		pc_src = src_next;
		compare_word("bubble instruction_id", nop_word, instruction_id);
		compare_word("bubble pc_next_id", 32'b0, pc_next_id);
		@(negedge clk);
		compare_word("target pc_id", target, pc_id);
		compare_word("target instruction_id", ref_mem[target[6:0]], instruction_id);
		compare_word("target pc_next_id", target + 1, pc_next_id);
	endtask

	task automatic redirect_flush();
		start_test("redirect_flush");
		redirect(src_branch, 32'd40);
		redirect(src_jump, 32'd90);
		redirect(src_register, 32'd7);
		end_test();
	endtask

	task automatic stall_hold();
		logic [31:0] held_instr;
		logic [31:0] held_pc;
		logic [31:0] held_next;
		start_test("stall_hold");
		@(negedge clk);
		held_instr = instruction_id;
		held_pc = pc_id;
		held_next = pc_next_id;
		stall = 1'b1;
		repeat (3) begin
			@(negedge clk);
			compare_word("held instruction_id", held_instr, instruction_id);
			compare_word("held pc_id", held_pc, pc_id);
			compare_word("held pc_next_id", held_next, pc_next_id);
		end
		stall = 1'b0;
		// pc was already one ahead when the stall began
		@(negedge clk);
		compare_word("resume pc_id", held_pc + 1, pc_id);
		compare_word("resume instruction_id", ref_mem[7'(held_pc + 1)], instruction_id);
		end_test();
	endtask

	task automatic halt_freeze();
		logic err;
		int   cycles;
		start_test("halt_freeze");
		set_run(1'b0);
		ref_mem[5] = {op_halt, 26'(next_random())};
		apb_write(12'h014, ref_mem[5], err);
		compare_word("halt word pslverr", 32'b0, {31'b0, err});
		set_run(1'b1);
		cycles = 0;
		while (!halt_id && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		assert (halt_id) else begin
			errors++;
			$display("%s: halt_id never rose after the halt word", current_test);
		end
		compare_word("halt pc_id", 32'd5, pc_id);
		compare_word("halt instruction_id", ref_mem[5], instruction_id);
		repeat (4) begin
			@(negedge clk);
			compare_word("halt_id held", 32'd1, {31'b0, halt_id});
			compare_word("frozen pc_id", 32'd5, pc_id);
		end
		end_test();
	endtask

	// still running and halted from the previous test
	task automatic write_protect();
		logic [31:0] data;
		logic        err;
		start_test("write_protect");
		apb_write(12'h024, ~ref_mem[9], err);
		compare_word("blocked pslverr", 32'd1, {31'b0, err});
		set_run(1'b0);
		apb_read(12'h024, data, err);
		compare_word("protected word", ref_mem[9], data);
		compare_word("halt_id after stop", 32'b0, {31'b0, halt_id});
		end_test();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// run sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		pc_src = src_next;
		branch_address = '0;
		jump_address = '0;
		register_address = '0;
		stall = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(negedge clk);
		preload_memory();
		load_readback();
		sequential_fetch();
		redirect_flush();
		stall_hold();
		halt_freeze();
		write_protect();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// twice the expected run length
	initial begin
		#(test_cycles * clock_period_ns * 2);
		$display("watchdog expired, the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sources.f ====
fetch_pkg.sv
pc_unit.sv
imem_apb.sv
if_id_latch.sv
fetch_stage.sv
tb_clock_gen.sv
fetch_tb.sv
